// File: bench/flash_model.sv
// Behavioral SPI flash, mode 0, serial read command only
// Byte at address a is the low byte of a*7 plus 8'h5A

`timescale 1ns/1ps
`default_nettype none

module flash_model (
    input  logic i_sck,
    input  logic i_ssb,
    input  logic i_mosi,
    output logic o_miso
);

    logic [31:0] cmd_addr;
    int          bit_cnt;

    function automatic logic [7:0] byte_at(input logic [23:0] a);
        logic [7:0] prod;
        prod = a[7:0] * 8'd7;
        return prod + 8'h5A;
    endfunction

    initial begin
        o_miso = 1'b0;
    end

    // Command and address are taken on rising sck
    always @(posedge i_sck or posedge i_ssb) begin
        if (i_ssb) begin
            bit_cnt <= 0;
        end else begin
            if (bit_cnt < 32) begin
                cmd_addr <= {cmd_addr[30:0], i_mosi};
            end
            bit_cnt <= bit_cnt + 1;
        end
    end

    // Data leaves on falling sck, MSB of each byte first
    always @(negedge i_sck) begin : shift_out
        int         k;
        logic [7:0] data;
        if (!i_ssb && bit_cnt >= 32) begin
            k = bit_cnt - 32;
            data = byte_at(cmd_addr[23:0] + k / 8);
            // Anything but the 03 read command returns zeros
            if (cmd_addr[31:24] != 8'h03) begin
                data = 8'h00;
            end
            o_miso <= data[7 - (k % 8)];
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_flash_soc.sv
// Testbench for the flash SoC top level
// LFSR stimulus, CPU bus driver tasks, flash content model,
// value checks and the closing report

`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module tb_flash_soc;

    localparam int FETCH_LIMIT = 600;
    localparam int DBUS_LIMIT  = 16;
    localparam int POLL_LIMIT  = 400;

    localparam logic [31:0] GPIO_ADR = {`SOC_GPIO_PAGE, 24'd0};
    localparam logic [31:0] BRG_ADR  = {`SOC_FLASH_PAGE, 20'd0, `SOC_BRG_ADDR_OFS};
    localparam logic [31:0] BRG_STAT = {`SOC_FLASH_PAGE, 20'd0, `SOC_BRG_STAT_OFS};

    logic        ck;
    logic        RESET_LOOP;
    logic        ibus_cyc;
    logic [31:0] ibus_adr;
    logic        ibus_ack;
    logic [31:0] ibus_rdt;
    logic        dbus_cyc;
    logic        dbus_we;
    logic [31:0] dbus_adr;
    logic [31:0] dbus_dat;
    logic [3:0]  dbus_sel;
    logic [31:0] dbus_rdt;
    logic        dbus_ack;
    logic        flash_sck;
    logic        flash_ssb;
    logic        flash_mosi;
    logic        flash_miso;
    logic [7:0]  gpio;

    logic [15:0] lfsr = 16'd33671;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_base;

    flash_soc_top dut (
        .ck(ck), .RESET_LOOP(RESET_LOOP),
        .i_ibus_cyc(ibus_cyc), .i_ibus_adr(ibus_adr),
        .o_ibus_ack(ibus_ack), .o_ibus_rdt(ibus_rdt),
        .i_dbus_cyc(dbus_cyc), .i_dbus_we(dbus_we), .i_dbus_adr(dbus_adr),
        .i_dbus_dat(dbus_dat), .i_dbus_sel(dbus_sel),
        .o_dbus_rdt(dbus_rdt), .o_dbus_ack(dbus_ack),
        .o_flash_sck(flash_sck), .o_flash_ssb(flash_ssb),
        .o_flash_mosi(flash_mosi), .i_flash_miso(flash_miso),
        .o_gpio(gpio)
    );

    flash_model u_flash (
        .i_sck(flash_sck), .i_ssb(flash_ssb), .i_mosi(flash_mosi), .o_miso(flash_miso)
    );

    initial begin
        ck = 1'b0;
        forever #10 ck = ~ck;
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected flash byte at address a
    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        logic [7:0] lo;
        lo = a[7:0];
        return (lo << 3) - lo + 8'h5A;
    endfunction

    function automatic logic [31:0] flash_word(input logic [31:0] adr);
        logic [23:0] a;
        a = adr[23:0];
        return {flash_byte(a + 24'd3), flash_byte(a + 24'd2),
                flash_byte(a + 24'd1), flash_byte(a)};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic begin_test();
        test_base = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d mismatches", name, errors - test_base);
        end
    endtask

    // CPU instruction fetch holding cyc until the one-cycle ack
    task automatic ibus_fetch(input logic [31:0] adr, output logic [31:0] rdt);
        int waited;
        @(negedge ck);
        ibus_cyc = 1'b1;
        ibus_adr = adr;
        waited = 0;
        rdt = 32'd0;
        do begin
            @(negedge ck);
            waited++;
        end while (ibus_ack !== 1'b1 && waited < FETCH_LIMIT);
        if (ibus_ack === 1'b1) begin
            rdt = ibus_rdt;
        end else begin
            errors++;
            $display("fetch at %h got no ack within %0d cycles", adr, FETCH_LIMIT);
        end
        ibus_cyc = 1'b0;
    endtask

    // One data bus access expecting its ack 2 cycles after cyc
    task automatic dbus_access(input logic we, input logic [31:0] adr,
                               input logic [31:0] dat, input logic [3:0] sel,
                               input string name, output logic [31:0] rdt);
        int waited;
        @(negedge ck);
        dbus_cyc = 1'b1;
        dbus_we  = we;
        dbus_adr = adr;
        dbus_dat = dat;
        dbus_sel = sel;
        waited = 0;
        rdt = 32'd0;
        do begin
            @(negedge ck);
            waited++;
        end while (dbus_ack !== 1'b1 && waited < DBUS_LIMIT);
        if (dbus_ack === 1'b1) begin
            rdt = dbus_rdt;
            check_equal({name, " ack latency"}, 32'd2, waited);
        end else begin
            errors++;
            $display("%s at %h got no data bus ack within %0d cycles", name, adr, DBUS_LIMIT);
        end
        dbus_cyc = 1'b0;
        dbus_we  = 1'b0;
    endtask

    // Poll status until valid with busy as the only other legal value
    task automatic wait_bridge_valid(input string name);
        logic [31:0] stat;
        int          polls;
        polls = 0;
        stat = 32'd1;
        while (stat !== 32'd2 && polls < POLL_LIMIT) begin
            dbus_access(1'b0, BRG_STAT, 32'd0, 4'hF, name, stat);
            polls++;
            if (stat !== 32'd1 && stat !== 32'd2) begin
                check_equal({name, " status"}, 32'd1, stat);
            end
        end
        if (stat !== 32'd2) begin
            errors++;
            $display("%s: bridge never reported valid after %0d polls", name, polls);
        end
    endtask

    initial begin
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] sel;
        logic [31:0] rd;
        logic [31:0] cpu_word;
        logic [31:0] brg_a;
        logic [31:0] brg_b;
        logic [31:0] cpu_adr [3];
        logic [7:0]  gpio_model;
        int          cpu_fetches;

        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        RESET_LOOP = 1'b1;
        ibus_cyc = 1'b0;
        ibus_adr = 32'd0;
        dbus_cyc = 1'b0;
        dbus_we  = 1'b0;
        dbus_adr = 32'd0;
        dbus_dat = 32'd0;
        dbus_sel = 4'd0;
        repeat (2) @(posedge ck);
        @(negedge ck);
        RESET_LOOP = 1'b0;

        begin_test();
        check_equal("reset ssb", 32'd1, flash_ssb);
        check_equal("reset sck", 32'd0, flash_sck);
        check_equal("reset ibus ack", 32'd0, ibus_ack);
        check_equal("reset dbus ack", 32'd0, dbus_ack);
        check_equal("reset gpio", 32'd0, gpio);
        end_test("reset");

        begin_test();
        for (int i = 0; i < 20; i++) begin
            take_bits(32, adr);
            ibus_fetch(adr, cpu_word);
            check_equal("ibus fetch", flash_word(adr), cpu_word);
        end
        end_test("ibus fetch");

        begin_test();
        gpio_model = 8'd0;
        for (int i = 0; i < 12; i++) begin
            take_bits(32, dat);
            take_bits(4, sel);
            dbus_access(1'b1, GPIO_ADR, dat, sel[3:0], "gpio write", rd);
            if (sel[0]) begin
                gpio_model = dat[7:0];
            end
            check_equal("gpio pins", gpio_model, gpio);
            dbus_access(1'b0, GPIO_ADR, 32'd0, 4'hF, "gpio read", rd);
            check_equal("gpio readback", {24'd0, gpio_model}, rd);
        end
        end_test("gpio");

        begin_test();
        take_bits(24, brg_a);
        dbus_access(1'b1, BRG_ADR, brg_a, 4'hF, "bridge start", rd);
        wait_bridge_valid("bridge poll");
        dbus_access(1'b0, BRG_ADR, 32'd0, 4'hF, "bridge word", rd);
        check_equal("bridge word", flash_word(brg_a), rd);
        end_test("bridge read");

        // Bridge waits behind the first CPU fetch and then holds off the next two
        begin_test();
        take_bits(24, brg_a);
        take_bits(24, brg_b);
        for (int i = 0; i < 3; i++) begin
            take_bits(32, cpu_adr[i]);
        end
        cpu_fetches = 0;
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    ibus_fetch(cpu_adr[i], cpu_word);
                    check_equal("contention cpu fetch", flash_word(cpu_adr[i]), cpu_word);
                    cpu_fetches++;
                    // Idle cycle lets the waiting bridge take the grant
                    @(negedge ck);
                end
            end
            begin
                repeat (6) @(negedge ck);
                dbus_access(1'b1, BRG_ADR, brg_a, 4'hF, "contention start", rd);
                dbus_access(1'b0, BRG_STAT, 32'd0, 4'hF, "contention status", rd);
                check_equal("contention busy", 32'd1, rd);
                dbus_access(1'b1, BRG_ADR, brg_b, 4'hF, "contention busy write", rd);
                wait_bridge_valid("contention poll");
                check_equal("contention order", 32'd1, cpu_fetches);
            end
        join
        dbus_access(1'b0, BRG_ADR, 32'd0, 4'hF, "contention word", rd);
        check_equal("contention bridge word", flash_word(brg_a), rd);
        end_test("contention");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            take_bits(32, adr);
            if (adr[31:24] == `SOC_GPIO_PAGE || adr[31:24] == `SOC_FLASH_PAGE) begin
                adr[24] = ~adr[24];
            end
            dbus_access(1'b0, adr, 32'd0, 4'hF, "unmapped read", rd);
            check_equal("unmapped data", 32'd0, rd);
        end
        end_test("unmapped");

        $display("tests run %0d, tests failed %0d, checks %0d, failures %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/soc_pkg.sv
source/bus_if.sv
source/spi_flash_fetch.sv
source/ibus_arb.sv
source/flash_read_bridge.sv
source/gpio_reg.sv
source/dbus_fabric.sv
source/flash_soc_top.sv
bench/flash_model.sv
bench/tb_flash_soc.sv

// File: source/bus_if.sv
// Instruction bus interface, cyc/ack handshake
// Data bus interface with byte selects

`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

interface ibus_if;
    logic                  cyc;
    logic [`SOC_BUS_W-1:0] adr;
    logic                  ack;
    logic [`SOC_BUS_W-1:0] rdt;

    modport master (
        output cyc, adr,
        input  ack, rdt
    );

    modport slave (
        input  cyc, adr,
        output ack, rdt
    );
endinterface

interface dbus_if;
    logic                  cyc;
    logic                  we;
    logic [`SOC_BUS_W-1:0] adr;
    logic [`SOC_BUS_W-1:0] dat;
    logic [`SOC_SEL_W-1:0] sel;
    logic [`SOC_BUS_W-1:0] rdt;
    logic                  ack;

    modport cpu (
        output cyc, we, adr, dat, sel,
        input  rdt, ack
    );

    modport fabric (
        input  cyc, we, adr, dat, sel,
        output rdt, ack
    );
endinterface

`default_nettype wire

// File: source/dbus_fabric.sv
// Data bus fabric
// Page decode, one-cycle device selects, registered OR of returns
// Unmapped pages get a zero ack from the fabric itself

`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module dbus_fabric
    import soc_pkg::*;
(
    input  logic        ck,
    input  logic        RESET_LOOP,
    dbus_if.fabric      bus,
    output logic        o_gpio_sel,
    output logic        o_flash_sel,
    input  logic [31:0] i_gpio_rdt,
    input  logic [31:0] i_flash_rdt,
    input  logic        i_gpio_ack,
    input  logic        i_flash_ack
);

    dbus_dev_t   dev;
    logic        pending;
    logic        start;
    logic        nomap_q;
    logic        ack_q;
    logic [31:0] rdt_q;

    always_comb begin
        case (bus.adr[31:24])
            `SOC_GPIO_PAGE:  dev = DEV_GPIO;
            `SOC_FLASH_PAGE: dev = DEV_FLASH;
            default:         dev = DEV_NONE;
        endcase
    end

    // One select per access
    assign start       = bus.cyc && !pending;
    assign o_gpio_sel  = start && (dev == DEV_GPIO);
    assign o_flash_sel = start && (dev == DEV_FLASH);

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            pending <= 1'b0;
            nomap_q <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            if (start) begin
                pending <= 1'b1;
            end else if (ack_q) begin
                pending <= 1'b0;
            end
            // Stands in for a device ack on unmapped pages
            nomap_q <= start && (dev == DEV_NONE);
            ack_q   <= i_gpio_ack || i_flash_ack || nomap_q;
        end
    end

    always_ff @(posedge ck) begin
        rdt_q <= i_gpio_rdt | i_flash_rdt;
    end

    assign bus.ack = ack_q;
    assign bus.rdt = rdt_q;

endmodule

`default_nettype wire

// File: source/flash_read_bridge.sv
// Data bus bridge for flash reads
// Address register at offset 0 starts a fetch, status at offset 4
// Fetches go out on the low priority instruction bus port

`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module flash_read_bridge
    import soc_pkg::*;
(
    input  logic          ck,
    input  logic          RESET_LOOP,
    input  logic          i_sel,
    input  logic          i_we,
    input  logic [31:0]   i_adr,
    input  logic [31:0]   i_dat,
    output logic [31:0]   o_rdt,
    output logic          o_ack,
    ibus_if.master        fetch
);

    brg_state_t  state;
    logic [31:0] addr_q;
    logic [31:0] word_q;
    logic [31:0] rdt_q;
    logic        ack_q;
    logic        wr_addr;
    logic        busy;
    logic        valid;

    assign wr_addr = i_sel && i_we && (i_adr[3:0] == `SOC_BRG_ADDR_OFS);
    assign busy    = (state == BRG_FETCH);
    assign valid   = (state == BRG_VALID);

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state <= BRG_IDLE;
            ack_q <= 1'b0;
            rdt_q <= 32'd0;
        end else begin
            ack_q <= i_sel;
            rdt_q <= 32'd0;
            if (i_sel && !i_we) begin
                case (i_adr[3:0])
                    `SOC_BRG_ADDR_OFS: rdt_q <= word_q;
                    `SOC_BRG_STAT_OFS: rdt_q <= {30'd0, valid, busy};
                    default:           rdt_q <= 32'd0;
                endcase
            end
            case (state)
                BRG_IDLE, BRG_VALID: begin
                    if (wr_addr) begin
                        state <= BRG_FETCH;
                    end
                end
                BRG_FETCH: begin
                    if (fetch.ack) begin
                        state <= BRG_VALID;
                    end
                end
                default: begin
                    state <= BRG_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ck) begin
        // Writes during a running fetch are dropped
        if (wr_addr && !busy) begin
            addr_q <= i_dat;
        end
        if (busy && fetch.ack) begin
            word_q <= fetch.rdt;
        end
    end

    assign fetch.cyc = busy;
    assign fetch.adr = addr_q;
    assign o_rdt     = rdt_q;
    assign o_ack     = ack_q;

endmodule

`default_nettype wire

// File: source/flash_soc_top.sv
// Flash side of the SoC
// CPU ports to bus interfaces, ibus arbiter, SPI fetch, flash bridge,
// GPIO register and data bus fabric

`timescale 1ns/1ps
`default_nettype none

module flash_soc_top (
    input  logic        ck,
    input  logic        RESET_LOOP,
    input  logic        i_ibus_cyc,
    input  logic [31:0] i_ibus_adr,
    output logic        o_ibus_ack,
    output logic [31:0] o_ibus_rdt,
    input  logic        i_dbus_cyc,
    input  logic        i_dbus_we,
    input  logic [31:0] i_dbus_adr,
    input  logic [31:0] i_dbus_dat,
    input  logic [3:0]  i_dbus_sel,
    output logic [31:0] o_dbus_rdt,
    output logic        o_dbus_ack,
    output logic        o_flash_sck,
    output logic        o_flash_ssb,
    output logic        o_flash_mosi,
    input  logic        i_flash_miso,
    output logic [7:0]  o_gpio
);

    ibus_if cpu_ibus ();
    ibus_if brg_ibus ();
    ibus_if flash_ibus ();
    dbus_if dbus ();

    logic        gpio_sel;
    logic        flash_sel;
    logic [31:0] gpio_rdt;
    logic [31:0] flash_rdt;
    logic        gpio_ack;
    logic        flash_ack;

    // CPU instruction bus
    assign cpu_ibus.cyc = i_ibus_cyc;
    assign cpu_ibus.adr = i_ibus_adr;
    assign o_ibus_ack   = cpu_ibus.ack;
    assign o_ibus_rdt   = cpu_ibus.rdt;

    // CPU data bus
    assign dbus.cyc   = i_dbus_cyc;
    assign dbus.we    = i_dbus_we;
    assign dbus.adr   = i_dbus_adr;
    assign dbus.dat   = i_dbus_dat;
    assign dbus.sel   = i_dbus_sel;
    assign o_dbus_rdt = dbus.rdt;
    assign o_dbus_ack = dbus.ack;

    // CPU has priority over the bridge
    ibus_arb u_arb (
        .ck(ck), .RESET_LOOP(RESET_LOOP),
        .cpu(cpu_ibus), .brg(brg_ibus), .dev(flash_ibus)
    );

    spi_flash_fetch u_spi (
        .ck(ck), .RESET_LOOP(RESET_LOOP), .bus(flash_ibus),
        .o_sck(o_flash_sck), .o_ssb(o_flash_ssb),
        .o_mosi(o_flash_mosi), .i_miso(i_flash_miso)
    );

    flash_read_bridge u_bridge (
        .ck(ck), .RESET_LOOP(RESET_LOOP), .i_sel(flash_sel), .i_we(dbus.we),
        .i_adr(dbus.adr), .i_dat(dbus.dat), .o_rdt(flash_rdt), .o_ack(flash_ack),
        .fetch(brg_ibus)
    );

    gpio_reg u_gpio (
        .ck(ck), .RESET_LOOP(RESET_LOOP), .i_sel(gpio_sel), .i_we(dbus.we),
        .i_byte_en(dbus.sel[0]), .i_dat(dbus.dat[7:0]),
        .o_rdt(gpio_rdt), .o_ack(gpio_ack), .o_gpio(o_gpio)
    );

    dbus_fabric u_fabric (
        .ck(ck), .RESET_LOOP(RESET_LOOP), .bus(dbus),
        .o_gpio_sel(gpio_sel), .o_flash_sel(flash_sel),
        .i_gpio_rdt(gpio_rdt), .i_flash_rdt(flash_rdt),
        .i_gpio_ack(gpio_ack), .i_flash_ack(flash_ack)
    );

endmodule

`default_nettype wire

// File: source/gpio_reg.sv
// 8-bit GPIO output register on the data bus
// Write through byte lane 0, read back zero-extended

`timescale 1ns/1ps
`default_nettype none

module gpio_reg (
    input  logic        ck,
    input  logic        RESET_LOOP,
    input  logic        i_sel,
    input  logic        i_we,
    input  logic        i_byte_en,
    input  logic [7:0]  i_dat,
    output logic [31:0] o_rdt,
    output logic        o_ack,
    output logic [7:0]  o_gpio
);

    logic [7:0]  gpio_q;
    logic [31:0] rdt_q;
    logic        ack_q;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            gpio_q <= 8'd0;
            rdt_q  <= 32'd0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= i_sel;
            // Return is zero outside the ack cycle
            rdt_q <= (i_sel && !i_we) ? {24'd0, gpio_q} : 32'd0;
            if (i_sel && i_we && i_byte_en) begin
                gpio_q <= i_dat;
            end
        end
    end

    assign o_rdt  = rdt_q;
    assign o_ack  = ack_q;
    assign o_gpio = gpio_q;

endmodule

`default_nettype wire

// File: source/ibus_arb.sv
// Fixed priority instruction bus arbiter
// CPU port wins over the bridge port, grant held until ack

`timescale 1ns/1ps
`default_nettype none

module ibus_arb
    import soc_pkg::*;
(
    input  logic   ck,
    input  logic   RESET_LOOP,
    ibus_if.slave  cpu,
    ibus_if.slave  brg,
    ibus_if.master dev
);

    arb_owner_t owner;
    logic       own_cpu;
    logic       own_brg;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (cpu.cyc) begin
                        owner <= OWN_CPU;
                    end else if (brg.cyc) begin
                        owner <= OWN_BRIDGE;
                    end
                end
                default: begin
                    // Release on the slave ack
                    if (dev.ack) begin
                        owner <= OWN_NONE;
                    end
                end
            endcase
        end
    end

    assign own_cpu = (owner == OWN_CPU);
    assign own_brg = (owner == OWN_BRIDGE);

    assign dev.cyc = (own_cpu && cpu.cyc) || (own_brg && brg.cyc);
    assign dev.adr = own_brg ? brg.adr : cpu.adr;

    // Return path only to the owner
    assign cpu.ack = own_cpu && dev.ack;
    assign cpu.rdt = own_cpu ? dev.rdt : 32'd0;
    assign brg.ack = own_brg && dev.ack;
    assign brg.rdt = own_brg ? dev.rdt : 32'd0;

endmodule

`default_nettype wire

// File: source/soc_consts.svh
// Memory map pages and bridge register offsets
// Serial flash read command and address length
// Bus widths shared by the bus interfaces

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Data bus pages, matched against adr[31:24]
`define SOC_GPIO_PAGE      8'h40
`define SOC_FLASH_PAGE     8'h70

// Flash bridge registers, matched against adr[3:0]
`define SOC_BRG_ADDR_OFS   4'h0
`define SOC_BRG_STAT_OFS   4'h4

// Standard serial read with 24 address bits
`define SOC_FLASH_CMD_READ 8'h03
`define SOC_FLASH_ABITS    24

`define SOC_BUS_W          32
`define SOC_SEL_W          4

`endif

// File: source/soc_pkg.sv
// Shared types for the flash SoC
// State enums for the SPI controller and the flash bridge
// Arbiter owner and data bus device selectors

`default_nettype none

package soc_pkg;

    typedef enum logic [2:0] {
        SPI_IDLE,
        SPI_CMD,
        SPI_ADDR,
        SPI_DATA,
        SPI_DONE
    } spi_state_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_CPU,
        OWN_BRIDGE
    } arb_owner_t;

    typedef enum logic [1:0] {
        BRG_IDLE,
        BRG_FETCH,
        BRG_VALID
    } brg_state_t;

    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_GPIO,
        DEV_FLASH
    } dbus_dev_t;

endpackage

`default_nettype wire

// File: source/spi_flash_fetch.sv
// SPI mode 0 flash read controller
// Serves one instruction bus slave port, one 32-bit word per fetch

`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module spi_flash_fetch
    import soc_pkg::*;
(
    input  logic  ck,
    input  logic  RESET_LOOP,
    ibus_if.slave bus,
    output logic  o_sck,
    output logic  o_ssb,
    output logic  o_mosi,
    input  logic  i_miso
);

    spi_state_t  state;
    logic [4:0]  bit_cnt;
    logic [31:0] shift_q;
    logic [31:0] rdt_q;
    logic        sck_q;
    logic        ssb_q;
    logic        ack_q;
    logic        start;
    logic        shifting_out;

    // No restart in the ack cycle, the master still holds cyc there
    assign start = (state == SPI_IDLE) && bus.cyc && !ack_q;
    assign shifting_out = (state == SPI_CMD) || (state == SPI_ADDR);

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state   <= SPI_IDLE;
            bit_cnt <= 5'd0;
            sck_q   <= 1'b0;
            ssb_q   <= 1'b1;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    if (start) begin
                        ssb_q   <= 1'b0;
                        bit_cnt <= 5'd0;
                        state   <= SPI_CMD;
                    end
                end
                SPI_CMD, SPI_ADDR: begin
                    sck_q <= ~sck_q;
                    // Count a bit on each falling sck
                    if (sck_q) begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (state == SPI_CMD && bit_cnt == 5'd7) begin
                            state <= SPI_ADDR;
                        end
                        if (state == SPI_ADDR && bit_cnt == 5'd31) begin
                            state <= SPI_DATA;
                        end
                    end
                end
                SPI_DATA: begin
                    sck_q <= ~sck_q;
                    if (sck_q) begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd31) begin
                            state <= SPI_DONE;
                        end
                    end
                end
                SPI_DONE: begin
                    // sck has been low for a cycle, safe to deselect
                    ssb_q <= 1'b1;
                    ack_q <= 1'b1;
                    state <= SPI_IDLE;
                end
                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (start) begin
            shift_q <= {`SOC_FLASH_CMD_READ, bus.adr[`SOC_FLASH_ABITS-1:0]};
        end else if (shifting_out && sck_q) begin
            shift_q <= {shift_q[30:0], 1'b0};
        end else if (state == SPI_DATA && !sck_q) begin
            // Sample on the rising sck edge
            shift_q <= {shift_q[30:0], i_miso};
        end
        // First byte off the wire lands in bits 7:0
        if (state == SPI_DONE) begin
            rdt_q <= {shift_q[7:0], shift_q[15:8], shift_q[23:16], shift_q[31:24]};
        end
    end

    assign o_sck   = sck_q;
    assign o_ssb   = ssb_q;
    assign o_mosi  = shift_q[31];
    assign bus.ack = ack_q;
    assign bus.rdt = rdt_q;

endmodule

`default_nettype wire
